/* rtl/feConfigPkg.sv */
// Front-end sizing constants for decode, instruction buffer and testbench; import where used.
package feConfigPkg;

  // ==================================================
  // Pipeline bandwidths
  // ==================================================
  localparam int fetchWidth    = 4;  // Instructions per fetch bundle.
  localparam int decodeWidth   = 8;  // Packet slots after splitting.
  localparam int dispatchWidth = 4;  // Packets removed per dispatch.

  // ==================================================
  // Instruction queue
  // ==================================================
  localparam int instQueue    = 32;  // Queue entries.
  localparam int instQueueLog = 5;   // Head and tail pointer width.
  localparam int branchCountW = 3;   // Holds 0 to 4.

  // Two dispatch groups of headroom, so one full decode bundle always fits.
  localparam int stallThreshold = instQueue - 2 * dispatchWidth;

endpackage

/* rtl/instFormatPkg.sv */
// Raw instruction formats, opcodes and decoded-packet bit layout shared by decode and buffer.
package instFormatPkg;

  // ==================================================
  // Raw 32-bit instruction, two decodings
  // ==================================================
  typedef union packed {
    struct packed {
      logic [5:0]  opcode;  // Shared top bits.
      logic [4:0]  rs;      // Source 1.
      logic [4:0]  rt;      // Source 2.
      logic [4:0]  rd;      // Destination.
      logic [10:0] func;    // ALU function.
    } rType;
    struct packed {
      logic [5:0]  opcode;  // Shared top bits.
      logic [4:0]  rs;      // Source / base.
      logic [4:0]  rt;      // Destination.
      logic [15:0] imm;     // Immediate or offset.
    } iType;
  } rawInst_t;

  // ==================================================
  // Opcodes
  // ==================================================
  localparam logic [5:0] opAlu        = 6'd0;   // R-type.
  localparam logic [5:0] opBeq        = 6'd4;   // Branch equal.
  localparam logic [5:0] opBne        = 6'd5;   // Branch not equal.
  localparam logic [5:0] opAddImm     = 6'd8;   // Add immediate.
  localparam logic [5:0] opLoad       = 6'd35;  // Plain load.
  localparam logic [5:0] opLoadUpdate = 6'd49;  // Load, then base += imm.

  // ==================================================
  // Decoded packet layout, LSB first
  // ==================================================
  localparam int decPacketW    = 72;
  localparam int pcLsb         = 0;   // 32 bits.
  localparam int opcodeLsb     = 32;  // 6 bits.
  localparam int destLsb       = 38;  // 5 bits.
  localparam int src1Lsb       = 43;  // 5 bits.
  localparam int src2Lsb       = 48;  // 5 bits.
  localparam int immLsb        = 53;  // 16 bits.
  localparam int branchBit     = 69;  // Conditional branch.
  localparam int secondHalfBit = 70;  // Update half of a split.
  // Bit 71 spare, kept zero.

endpackage

/* rtl/multiPortRam.sv */
// Queue storage array with eight write ports and four asynchronous read ports.
`timescale 1ns/1ps

module multiPortRam #(
  parameter int depth = 32,
  parameter int width = 72
) (
  input  logic                     clk,
  input  logic                     we0_i,
  input  logic                     we1_i,
  input  logic                     we2_i,
  input  logic                     we3_i,
  input  logic                     we4_i,
  input  logic                     we5_i,
  input  logic                     we6_i,
  input  logic                     we7_i,
  input  logic [$clog2(depth)-1:0] waddr0_i,
  input  logic [$clog2(depth)-1:0] waddr1_i,
  input  logic [$clog2(depth)-1:0] waddr2_i,
  input  logic [$clog2(depth)-1:0] waddr3_i,
  input  logic [$clog2(depth)-1:0] waddr4_i,
  input  logic [$clog2(depth)-1:0] waddr5_i,
  input  logic [$clog2(depth)-1:0] waddr6_i,
  input  logic [$clog2(depth)-1:0] waddr7_i,
  input  logic [width-1:0]         wdata0_i,
  input  logic [width-1:0]         wdata1_i,
  input  logic [width-1:0]         wdata2_i,
  input  logic [width-1:0]         wdata3_i,
  input  logic [width-1:0]         wdata4_i,
  input  logic [width-1:0]         wdata5_i,
  input  logic [width-1:0]         wdata6_i,
  input  logic [width-1:0]         wdata7_i,
  input  logic [$clog2(depth)-1:0] raddr0_i,
  input  logic [$clog2(depth)-1:0] raddr1_i,
  input  logic [$clog2(depth)-1:0] raddr2_i,
  input  logic [$clog2(depth)-1:0] raddr3_i,
  output logic [width-1:0]         rdata0_o,
  output logic [width-1:0]         rdata1_o,
  output logic [width-1:0]         rdata2_o,
  output logic [width-1:0]         rdata3_o
);

  localparam int addrW = $clog2(depth);

  logic [width-1:0] mem [depth];    // Queue entries.
  logic [7:0]       we;              // Port enables, port 0 at bit 0.
  logic [addrW-1:0] waddr [8];
  logic [width-1:0] wdata [8];

  assign we    = {we7_i, we6_i, we5_i, we4_i, we3_i, we2_i, we1_i, we0_i};
  assign waddr = '{waddr0_i, waddr1_i, waddr2_i, waddr3_i, waddr4_i, waddr5_i, waddr6_i, waddr7_i};
  assign wdata = '{wdata0_i, wdata1_i, wdata2_i, wdata3_i, wdata4_i, wdata5_i, wdata6_i, wdata7_i};

  // Writer keeps addresses distinct, so port order never matters.
  always_ff @(posedge clk) begin
    for (int p = 0; p < 8; p++) begin
      if (we[p]) begin
        mem[waddr[p]] <= wdata[p];  // Enabled port lands.
      end
    end
  end

  assign rdata0_o = mem[raddr0_i];  // Async read.
  assign rdata1_o = mem[raddr1_i];
  assign rdata2_o = mem[raddr2_i];
  assign rdata3_o = mem[raddr3_i];

endmodule

/* rtl/instDecode.sv */
// Decode stage: splits and packs a fetch bundle into one registered eight-slot packet bundle.
`timescale 1ns/1ps

module instDecode (
  input  logic                                 clk,
  input  logic                                 reset_i,
  input  logic                                 flush_i,
  input  logic                                 stallFetch_i,
  input  logic                                 fetchValid_i,
  input  logic [feConfigPkg::fetchWidth-1:0]   fetchVector_i,
  input  logic [31:0]                          fetchPc_i,
  input  instFormatPkg::rawInst_t              fetchInst0_i,
  input  instFormatPkg::rawInst_t              fetchInst1_i,
  input  instFormatPkg::rawInst_t              fetchInst2_i,
  input  instFormatPkg::rawInst_t              fetchInst3_i,
  output logic                                 decodeReady_o,
  output logic [feConfigPkg::decodeWidth-1:0]  decodeVector_o,
  output logic [instFormatPkg::decPacketW-1:0] decPacket0_o,
  output logic [instFormatPkg::decPacketW-1:0] decPacket1_o,
  output logic [instFormatPkg::decPacketW-1:0] decPacket2_o,
  output logic [instFormatPkg::decPacketW-1:0] decPacket3_o,
  output logic [instFormatPkg::decPacketW-1:0] decPacket4_o,
  output logic [instFormatPkg::decPacketW-1:0] decPacket5_o,
  output logic [instFormatPkg::decPacketW-1:0] decPacket6_o,
  output logic [instFormatPkg::decPacketW-1:0] decPacket7_o
);

  import feConfigPkg::*;
  import instFormatPkg::*;

  rawInst_t               inst [fetchWidth];        // Bundle in program order.
  logic [decPacketW-1:0]  slotNext [decodeWidth];   // Packed packets, this cycle.
  logic [decodeWidth-1:0] vectorNext;
  logic [decPacketW-1:0]  slotReg [decodeWidth];    // Decode register.
  logic [decodeWidth-1:0] vectorReg;
  logic                   readyReg;

  assign inst = '{fetchInst0_i, fetchInst1_i, fetchInst2_i, fetchInst3_i};

  // Assembles one packet; spare bit stays zero.
  function automatic logic [decPacketW-1:0] makePacket(
    input logic [31:0] pc,
    input logic [5:0]  opcode,
    input logic [4:0]  dest,
    input logic [4:0]  src1,
    input logic [4:0]  src2,
    input logic [15:0] imm,
    input logic        isBranch,
    input logic        secondHalf
  );
    logic [decPacketW-1:0] pkt;
    pkt                  = '0;
    pkt[pcLsb +: 32]     = pc;
    pkt[opcodeLsb +: 6]  = opcode;
    pkt[destLsb +: 5]    = dest;
    pkt[src1Lsb +: 5]    = src1;
    pkt[src2Lsb +: 5]    = src2;
    pkt[immLsb +: 16]    = imm;
    pkt[branchBit]       = isBranch;
    pkt[secondHalfBit]   = secondHalf;
    return pkt;
  endfunction

  // ==================================================
  // Decode, split and pack toward slot 0
  // ==================================================
  always_comb begin : packSlots
    logic [3:0]  pos;    // Next free slot, reaches 8.
    logic [31:0] pc;
    logic [5:0]  op;
    pos        = '0;
    vectorNext = '0;
    for (int s = 0; s < decodeWidth; s++) begin
      slotNext[s] = '0;
    end
    for (int k = 0; k < fetchWidth; k++) begin
      pc = fetchPc_i + 32'(4 * k);  // Word-sized steps.
      op = inst[k].rType.opcode;    // Same bits in both views.
      if (fetchValid_i && fetchVector_i[k]) begin
        if (op == opAlu) begin
          slotNext[pos[2:0]] = makePacket(pc, op, inst[k].rType.rd, inst[k].rType.rs,
                                          inst[k].rType.rt, {5'd0, inst[k].rType.func},
                                          1'b0, 1'b0);
        end else if (op == opLoadUpdate) begin
          // Load half first.
          slotNext[pos[2:0]]   = makePacket(pc, opLoad, inst[k].iType.rt, inst[k].iType.rs,
                                            5'd0, inst[k].iType.imm, 1'b0, 1'b0);
          vectorNext[pos[2:0]] = 1'b1;
          pos                  = pos + 4'd1;
          // Then base register update.
          slotNext[pos[2:0]]   = makePacket(pc, opAddImm, inst[k].iType.rs, inst[k].iType.rs,
                                            5'd0, inst[k].iType.imm, 1'b0, 1'b1);
        end else begin
          slotNext[pos[2:0]] = makePacket(pc, op, inst[k].iType.rt, inst[k].iType.rs, 5'd0,
                                          inst[k].iType.imm, (op == opBeq) || (op == opBne),
                                          1'b0);
        end
        vectorNext[pos[2:0]] = 1'b1;  // Slot now occupied.
        pos                  = pos + 4'd1;
      end
    end
  end

  // ==================================================
  // Decode register, held while fetch is stalled
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      readyReg  <= 1'b0;  // Drop in-flight bundle.
      vectorReg <= '0;
    end else if (!stallFetch_i) begin
      readyReg  <= fetchValid_i;
      vectorReg <= vectorNext;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallFetch_i) begin
      slotReg <= slotNext;  // Payload only.
    end
  end

  assign decodeReady_o  = readyReg;
  assign decodeVector_o = vectorReg;
  assign decPacket0_o   = slotReg[0];
  assign decPacket1_o   = slotReg[1];
  assign decPacket2_o   = slotReg[2];
  assign decPacket3_o   = slotReg[3];
  assign decPacket4_o   = slotReg[4];
  assign decPacket5_o   = slotReg[5];
  assign decPacket6_o   = slotReg[6];
  assign decPacket7_o   = slotReg[7];

endmodule

/* rtl/instBuffer.sv */
// Circular instruction queue: tail writes from decode, four-wide head dispatch, fetch stall.
`timescale 1ns/1ps

module instBuffer (
  input  logic                                 clk,
  input  logic                                 reset_i,
  input  logic                                 flush_i,
  input  logic                                 stall_i,
  input  logic                                 decodeReady_i,
  input  logic [feConfigPkg::decodeWidth-1:0]  decodeVector_i,
  input  logic [instFormatPkg::decPacketW-1:0] decPacket0_i,
  input  logic [instFormatPkg::decPacketW-1:0] decPacket1_i,
  input  logic [instFormatPkg::decPacketW-1:0] decPacket2_i,
  input  logic [instFormatPkg::decPacketW-1:0] decPacket3_i,
  input  logic [instFormatPkg::decPacketW-1:0] decPacket4_i,
  input  logic [instFormatPkg::decPacketW-1:0] decPacket5_i,
  input  logic [instFormatPkg::decPacketW-1:0] decPacket6_i,
  input  logic [instFormatPkg::decPacketW-1:0] decPacket7_i,
  output logic                                 stallFetch_o,
  output logic                                 dispatchReady_o,
  output logic [instFormatPkg::decPacketW-1:0] dispatchPacket0_o,
  output logic [instFormatPkg::decPacketW-1:0] dispatchPacket1_o,
  output logic [instFormatPkg::decPacketW-1:0] dispatchPacket2_o,
  output logic [instFormatPkg::decPacketW-1:0] dispatchPacket3_o,
  output logic [feConfigPkg::branchCountW-1:0] branchCount_o
);

  import feConfigPkg::*;
  import instFormatPkg::*;

  logic [instQueueLog-1:0] headPtr;
  logic [instQueueLog-1:0] tailPtr;
  logic [instQueueLog:0]   instCount;                 // Occupancy, 0 to 32.
  logic [instQueueLog:0]   countNext;
  logic [decodeWidth-1:0]  writeEnable;
  logic [3:0]              writeNum;                  // Packets written, 0 to 8.
  logic [instQueueLog-1:0] writeAddr [decodeWidth];
  logic [instQueueLog-1:0] readAddr [dispatchWidth];
  logic [decPacketW-1:0]   headPacket [dispatchWidth];
  logic                    stallFetch;
  logic                    dispatchFire;

  // ==================================================
  // Status from occupancy
  // ==================================================
  assign stallFetch      = (instCount > (instQueueLog + 1)'(stallThreshold));
  assign dispatchReady_o = (instCount >= (instQueueLog + 1)'(dispatchWidth));
  assign dispatchFire    = dispatchReady_o & ~stall_i;  // Head group leaves.
  assign stallFetch_o    = stallFetch;

  // Write only what decode really hands over.
  assign writeEnable = {decodeWidth{decodeReady_i & ~stallFetch}} & decodeVector_i;

  always_comb begin
    writeNum = '0;
    for (int i = 0; i < decodeWidth; i++) begin
      writeNum = writeNum + {3'd0, writeEnable[i]};
    end
    for (int i = 0; i < decodeWidth; i++) begin
      writeAddr[i] = tailPtr + instQueueLog'(i);  // Wraps at queue end.
    end
    for (int j = 0; j < dispatchWidth; j++) begin
      readAddr[j] = headPtr + instQueueLog'(j);
    end
  end

  always_comb begin
    countNext = instCount + {2'd0, writeNum};
    if (dispatchFire) begin
      countNext = countNext - (instQueueLog + 1)'(dispatchWidth);
    end
  end

  // ==================================================
  // Pointers and count
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else begin
      tailPtr   <= tailPtr + instQueueLog'(writeNum);
      instCount <= countNext;
      if (dispatchFire) begin
        headPtr <= headPtr + instQueueLog'(dispatchWidth);
      end
    end
  end

  multiPortRam #(
    .depth (instQueue),
    .width (decPacketW)
  ) i_ram (
    .clk      (clk),
    .we0_i    (writeEnable[0]),
    .we1_i    (writeEnable[1]),
    .we2_i    (writeEnable[2]),
    .we3_i    (writeEnable[3]),
    .we4_i    (writeEnable[4]),
    .we5_i    (writeEnable[5]),
    .we6_i    (writeEnable[6]),
    .we7_i    (writeEnable[7]),
    .waddr0_i (writeAddr[0]),
    .waddr1_i (writeAddr[1]),
    .waddr2_i (writeAddr[2]),
    .waddr3_i (writeAddr[3]),
    .waddr4_i (writeAddr[4]),
    .waddr5_i (writeAddr[5]),
    .waddr6_i (writeAddr[6]),
    .waddr7_i (writeAddr[7]),
    .wdata0_i (decPacket0_i),
    .wdata1_i (decPacket1_i),
    .wdata2_i (decPacket2_i),
    .wdata3_i (decPacket3_i),
    .wdata4_i (decPacket4_i),
    .wdata5_i (decPacket5_i),
    .wdata6_i (decPacket6_i),
    .wdata7_i (decPacket7_i),
    .raddr0_i (readAddr[0]),
    .raddr1_i (readAddr[1]),
    .raddr2_i (readAddr[2]),
    .raddr3_i (readAddr[3]),
    .rdata0_o (headPacket[0]),
    .rdata1_o (headPacket[1]),
    .rdata2_o (headPacket[2]),
    .rdata3_o (headPacket[3])
  );

  // Branches in the dispatch window.
  always_comb begin
    branchCount_o = '0;
    for (int j = 0; j < dispatchWidth; j++) begin
      branchCount_o = branchCount_o + branchCountW'(headPacket[j][branchBit]);
    end
  end

  assign dispatchPacket0_o = headPacket[0];  // Oldest.
  assign dispatchPacket1_o = headPacket[1];
  assign dispatchPacket2_o = headPacket[2];
  assign dispatchPacket3_o = headPacket[3];

endmodule

/* rtl/frontEndTop.sv */
// Front-end slice top: decode stage feeding the instruction buffer.
`timescale 1ns/1ps

module frontEndTop (
  input  logic                                 clk,
  input  logic                                 reset_i,
  input  logic                                 flush_i,
  input  logic                                 stall_i,
  input  logic                                 fetchValid_i,
  input  logic [feConfigPkg::fetchWidth-1:0]   fetchVector_i,
  input  logic [31:0]                          fetchPc_i,
  input  instFormatPkg::rawInst_t              fetchInst0_i,
  input  instFormatPkg::rawInst_t              fetchInst1_i,
  input  instFormatPkg::rawInst_t              fetchInst2_i,
  input  instFormatPkg::rawInst_t              fetchInst3_i,
  output logic                                 stallFetch_o,
  output logic                                 dispatchReady_o,
  output logic [instFormatPkg::decPacketW-1:0] dispatchPacket0_o,
  output logic [instFormatPkg::decPacketW-1:0] dispatchPacket1_o,
  output logic [instFormatPkg::decPacketW-1:0] dispatchPacket2_o,
  output logic [instFormatPkg::decPacketW-1:0] dispatchPacket3_o,
  output logic [feConfigPkg::branchCountW-1:0] branchCount_o
);

  import feConfigPkg::*;
  import instFormatPkg::*;

  logic                   decodeReady;
  logic [decodeWidth-1:0] decodeVector;  // Contiguous from bit 0.
  logic [decPacketW-1:0]  decPacket [decodeWidth];

  instDecode i_decode (
    .clk            (clk),
    .reset_i        (reset_i),
    .flush_i        (flush_i),
    .stallFetch_i   (stallFetch_o),  // Hold on queue pressure.
    .fetchValid_i   (fetchValid_i),
    .fetchVector_i  (fetchVector_i),
    .fetchPc_i      (fetchPc_i),
    .fetchInst0_i   (fetchInst0_i),
    .fetchInst1_i   (fetchInst1_i),
    .fetchInst2_i   (fetchInst2_i),
    .fetchInst3_i   (fetchInst3_i),
    .decodeReady_o  (decodeReady),
    .decodeVector_o (decodeVector),
    .decPacket0_o   (decPacket[0]),
    .decPacket1_o   (decPacket[1]),
    .decPacket2_o   (decPacket[2]),
    .decPacket3_o   (decPacket[3]),
    .decPacket4_o   (decPacket[4]),
    .decPacket5_o   (decPacket[5]),
    .decPacket6_o   (decPacket[6]),
    .decPacket7_o   (decPacket[7])
  );

  instBuffer i_buffer (
    .clk               (clk),
    .reset_i           (reset_i),
    .flush_i           (flush_i),
    .stall_i           (stall_i),
    .decodeReady_i     (decodeReady),
    .decodeVector_i    (decodeVector),
    .decPacket0_i      (decPacket[0]),
    .decPacket1_i      (decPacket[1]),
    .decPacket2_i      (decPacket[2]),
    .decPacket3_i      (decPacket[3]),
    .decPacket4_i      (decPacket[4]),
    .decPacket5_i      (decPacket[5]),
    .decPacket6_i      (decPacket[6]),
    .decPacket7_i      (decPacket[7]),
    .stallFetch_o      (stallFetch_o),
    .dispatchReady_o   (dispatchReady_o),
    .dispatchPacket0_o (dispatchPacket0_o),
    .dispatchPacket1_o (dispatchPacket1_o),
    .dispatchPacket2_o (dispatchPacket2_o),
    .dispatchPacket3_o (dispatchPacket3_o),
    .branchCount_o     (branchCount_o)
  );

endmodule

/* tb/frontEndTb.sv */
// Directed testbench for the decode-to-dispatch slice; compile from list.f, top is frontEndTb.
`timescale 1ns/1ps

module frontEndTb;

  import feConfigPkg::*;
  import instFormatPkg::*;

  localparam int clkPeriod   = 100;
  localparam int bundleTotal = 38;  // Test bundles plus drain padding.

  logic                    clk;
  logic                    reset;
  logic                    flush;
  logic                    stall;
  logic                    fetchValid;
  logic [fetchWidth-1:0]   fetchVector;
  logic [31:0]             fetchPc;
  rawInst_t                fetchInst [fetchWidth];
  logic                    stallFetch;
  logic                    dispatchReady;
  logic [decPacketW-1:0]   dispPkt [dispatchWidth];
  logic [branchCountW-1:0] branchCount;

  logic [decPacketW-1:0] modelQ [$];   // Expected packets, oldest first.
  rawInst_t              stage [fetchWidth];
  logic [31:0]           nextPc;
  logic [31:0]           lcgState = 32'd11;
  int                    errCount;
  int                    checkCount;

  frontEndTop i_dut (
    .clk               (clk),
    .reset_i           (reset),
    .flush_i           (flush),
    .stall_i           (stall),
    .fetchValid_i      (fetchValid),
    .fetchVector_i     (fetchVector),
    .fetchPc_i         (fetchPc),
    .fetchInst0_i      (fetchInst[0]),
    .fetchInst1_i      (fetchInst[1]),
    .fetchInst2_i      (fetchInst[2]),
    .fetchInst3_i      (fetchInst[3]),
    .stallFetch_o      (stallFetch),
    .dispatchReady_o   (dispatchReady),
    .dispatchPacket0_o (dispPkt[0]),
    .dispatchPacket1_o (dispPkt[1]),
    .dispatchPacket2_o (dispPkt[2]),
    .dispatchPacket3_o (dispPkt[3]),
    .branchCount_o     (branchCount)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // ==================================================
  // Stimulus helpers and reference model
  // ==================================================
  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Opcode mix per test mode. Mode 3 is all split loads.
  function automatic logic [5:0] pickOp(input int mode);
    int unsigned sel;
    sel = (nextRand() >> 16) % 3;
    case (mode)
      0:       return (sel == 0) ? opAddImm : opAlu;
      1:       return (sel == 0) ? opLoadUpdate : ((sel == 1) ? opLoad : opAlu);
      2:       return (sel == 0) ? opBeq : ((sel == 1) ? opBne : opAddImm);
      default: return opLoadUpdate;
    endcase
  endfunction

  function automatic rawInst_t randInst(input logic [5:0] op);
    rawInst_t inst;
    inst              = nextRand();  // Random register and immediate fields.
    inst.rType.opcode = op;
    return inst;
  endfunction

  // Packet as {spare, secondHalf, branch, imm, src2, src1, dest, opcode, pc}.
  task automatic expandInst(input rawInst_t in, input logic [31:0] pc);
    logic [5:0] op;
    logic       isBranch;
    op       = in.iType.opcode;
    isBranch = (op == opBeq) || (op == opBne);
    if (op == opAlu) begin
      modelQ.push_back({3'b000, {5'd0, in.rType.func}, in.rType.rt, in.rType.rs,
                        in.rType.rd, op, pc});
    end else if (op == opLoadUpdate) begin
      modelQ.push_back({3'b000, in.iType.imm, 5'd0, in.iType.rs, in.iType.rt, opLoad, pc});
      modelQ.push_back({3'b010, in.iType.imm, 5'd0, in.iType.rs, in.iType.rs, opAddImm, pc});
    end else begin
      modelQ.push_back({2'b00, isBranch, in.iType.imm, 5'd0, in.iType.rs, in.iType.rt, op, pc});
    end
  endtask

  task automatic checkValue(input logic [decPacketW-1:0] got, input logic [decPacketW-1:0] exp,
                            input string what);
    checkCount++;
    assert (got === exp) else begin
      errCount++;
      $display("** Error [%0t] %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkDispatch();
    logic [decPacketW-1:0] expPkt;
    int                    branches;
    branches = 0;
    checkCount++;
    assert (modelQ.size() >= dispatchWidth) else begin
      errCount++;
      $display("Unexpected dispatch at %0t: reference queue holds only %0d packets",
               $time, modelQ.size());
    end
    if (modelQ.size() >= dispatchWidth) begin
      for (int j = 0; j < dispatchWidth; j++) begin
        expPkt   = modelQ.pop_front();
        branches = branches + expPkt[branchBit];
        checkValue(dispPkt[j], expPkt, $sformatf("dispatch slot %0d", j));
      end
      checkValue(branchCount, branches, "branchCount_o");
    end
  endtask

  // Values read here are the ones just before the edge.
  always @(posedge clk) begin
    if (reset || flush) begin
      modelQ.delete();  // Queue and decode register both emptied.
    end else begin
      if (dispatchReady && !stall) begin
        checkDispatch();
      end
      if (fetchValid && !stallFetch) begin
        for (int k = 0; k < fetchWidth; k++) begin
          if (fetchVector[k]) begin
            expandInst(fetchInst[k], fetchPc + 32'(4 * k));
          end
        end
      end
    end
  end

  task automatic sendBundle(input logic [fetchWidth-1:0] vec);
    @(negedge clk);
    fetchValid  = 1'b1;
    fetchVector = vec;
    fetchPc     = nextPc;
    fetchInst   = stage;
    nextPc      = nextPc + 32'd16;
    while (stallFetch) begin
      @(negedge clk);  // Hold until taken.
    end
  endtask

  task automatic idleFetch();
    @(negedge clk);
    fetchValid  = 1'b0;
    fetchVector = '0;
  endtask

  task automatic runBundles(input int n, input int mode, input bit sparse);
    for (int b = 0; b < n; b++) begin
      for (int k = 0; k < fetchWidth; k++) begin
        stage[k] = randInst(pickOp(mode));
      end
      sendBundle(sparse ? 4'(nextRand() >> 8) : 4'hF);
    end
  endtask

  // Tops up a partial group with ALU ops, then waits for the model to empty.
  task automatic drainQueue();
    int pad;
    idleFetch();
    while (modelQ.size() >= dispatchWidth) @(negedge clk);
    pad = (dispatchWidth - modelQ.size() % dispatchWidth) % dispatchWidth;
    if (pad != 0) begin
      for (int k = 0; k < fetchWidth; k++) begin
        stage[k] = randInst(opAlu);
      end
      sendBundle(4'((1 << pad) - 1));
      idleFetch();
    end
    while (modelQ.size() != 0) @(negedge clk);
  endtask

  task automatic reportTest(input string name, input int errBefore);
    $display("%-14s %s", name, (errCount == errBefore) ? "ok" : "mismatches");
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic testBackPressure();
    int errBefore;
    errBefore = errCount;
    @(negedge clk);
    stall = 1'b1;               // Head frozen.
    runBundles(5, 3, 1'b0);     // 40 packets, past the threshold.
    for (int k = 0; k < fetchWidth; k++) begin
      stage[k] = randInst(opLoadUpdate);
    end
    fork
      sendBundle(4'hF);         // Must wait for room.
      begin
        repeat (6) @(negedge clk);
        checkValue(stallFetch, 1'b1, "stallFetch_o under stall");
        stall = 1'b0;
      end
    join
    drainQueue();
    reportTest("backPressure", errBefore);
  endtask

  task automatic testFlush();
    int errBefore;
    errBefore = errCount;
    @(negedge clk);
    stall = 1'b1;
    runBundles(3, 0, 1'b0);     // Last bundle still in decode at the flush.
    @(negedge clk);
    flush = 1'b1;               // Bundle still on the fetch inputs is dropped too.
    @(negedge clk);
    flush       = 1'b0;
    fetchValid  = 1'b0;
    fetchVector = '0;
    stall       = 1'b0;
    checkValue(dispatchReady, 1'b0, "dispatchReady_o after flush");
    @(negedge clk);
    checkValue(dispatchReady, 1'b0, "dispatchReady_o with decode emptied");
    nextPc = 32'h0000_8000;     // New path after the redirect.
    runBundles(4, 1, 1'b0);
    drainQueue();
    reportTest("flush", errBefore);
  endtask

  // ==================================================
  // Sequence
  // ==================================================
  initial begin
    int errBefore;
    reset       = 1'b1;
    flush       = 1'b0;
    stall       = 1'b0;
    fetchValid  = 1'b0;
    fetchVector = '0;
    fetchPc     = '0;
    nextPc      = 32'h0000_1000;
    errCount    = 0;
    checkCount  = 0;
    for (int k = 0; k < fetchWidth; k++) begin
      fetchInst[k] = '0;
      stage[k]     = '0;
    end
    repeat (3) @(negedge clk);
    reset = 1'b0;

    errBefore = errCount;
    checkValue(stallFetch, 1'b0, "stallFetch_o after reset");
    checkValue(dispatchReady, 1'b0, "dispatchReady_o after reset");
    checkValue(branchCount, '0, "branchCount_o after reset");
    reportTest("reset", errBefore);

    errBefore = errCount;
    runBundles(6, 0, 1'b0);     // R-type and immediate views.
    drainQueue();
    reportTest("aluBundles", errBefore);

    errBefore = errCount;
    runBundles(8, 1, 1'b1);     // Sparse vectors with splits.
    drainQueue();
    reportTest("sparseSplit", errBefore);

    errBefore = errCount;
    runBundles(6, 2, 1'b0);
    drainQueue();
    reportTest("branchMix", errBefore);

    testBackPressure();
    testFlush();

    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Twenty cycles per bundle covers the slowest drain.
  initial begin
    #(clkPeriod * (bundleTotal * 20 + 100));
    $display("Timeout: the tests did not finish in time, the queue stopped draining");
    $display("** FAIL **");
    $finish;
  end

endmodule

/* list.f */
rtl/feConfigPkg.sv
rtl/instFormatPkg.sv
rtl/multiPortRam.sv
rtl/instDecode.sv
rtl/instBuffer.sv
rtl/frontEndTop.sv
tb/frontEndTb.sv
